// ==== arith_consts.svh ====
`ifndef ARITH_CONSTS_SVH
`define ARITH_CONSTS_SVH

// operand and result word width in bits, at least 2
`define ARITH_WIDTH 16

// prefix network choice for the subtractor
// 0 serial chain
// 1 Brent-Kung
// 2 Sklansky
`define ARITH_SPEED 2

`endif

// ==== arithPkg.sv ====
`include "arith_consts.svh"

package arithPkg;

	// operand / result word
	typedef logic [`ARITH_WIDTH-1:0] word_t;

	// request opcodes, unused encodings decode as OP_SUB
	typedef enum logic [2:0] {
		OP_SUB = 3'd0, // a - b
		OP_SBC = 3'd1, // a - b - borrowIn
		OP_CMP = 3'd2, // flags only
		OP_MIN = 3'd3, // signed min
		OP_MAX = 3'd4  // signed max
	} arithOp_e;

	// four-phase receiver states
	typedef enum logic [1:0] {
		IDLE = 2'd0, // waiting for req
		BUSY = 2'd1, // request travelling down the stages
		DONE = 2'd2  // ack up, waiting for it to drop
	} hsState_e;

endpackage

// ==== arithIf.sv ====
`timescale 1ns/10ps

interface arithIf;
	import arithPkg::*;

	logic valid; // one-cycle stage strobe
	logic carry; // borrow into the subtractor
	arithOp_e oper;
	word_t opA;
	word_t opB;
	word_t diff; // execute side only
	logic ovf;
	logic zflag; // prefix zero flag, good for carry 0

	// decode -> execute
	modport dec (output valid, carry, oper, opA, opB);
	modport exeIn (input valid, carry, oper, opA, opB);

	// execute -> result
	modport exeOut (output valid, carry, oper, opA, opB, diff, ovf, zflag);
	modport res (input valid, carry, oper, opA, opB, diff, ovf, zflag);

endinterface

// ==== prefixAndOr.sv ====
`timescale 1ns/10ps

module prefixAndOr #(
	parameter int width = 8, // word width
	parameter int speed = 2  // 0 serial, 1 Brent-Kung, 2 Sklansky
) (
	input logic [width-1:0] GI, // bit generate
	input logic [width-1:0] PI, // bit propagate
	output logic [width-1:0] GO, // group generate from bit 0
	output logic [width-1:0] PO  // group propagate from bit 0
);

	localparam int n = width;
	localparam int m = $clog2(width); // tree depth

	if (speed == 2) begin : sklansky
		wire [n-1:0] gT [0:m]; // one row per level
		wire [n-1:0] pT [0:m];

		assign gT[0] = GI;
		assign pT[0] = PI;
		for (genvar l = 1; l <= m; l++) begin : lvl
			for (genvar j = 0; j < n; j++) begin : node
				// upper half of each 2**l block takes the top of the lower half
				if (((j >> (l - 1)) % 2) == 1) begin : black
					localparam int src = ((j >> (l - 1)) << (l - 1)) - 1;
					assign gT[l][j] = gT[l-1][j] | (pT[l-1][j] & gT[l-1][src]);
					assign pT[l][j] = pT[l-1][j] & pT[l-1][src];
				end else begin : white
					assign gT[l][j] = gT[l-1][j];
					assign pT[l][j] = pT[l-1][j];
				end
			end
		end
		assign GO = gT[m];
		assign PO = pT[m];
	end else if (speed == 1) begin : brentKung
		wire [n-1:0] gT [0:2*m-1]; // up tree then down tree
		wire [n-1:0] pT [0:2*m-1];

		assign gT[0] = GI;
		assign pT[0] = PI;
		// up sweep, every 2**l-th node folds in its left neighbour group
		for (genvar l = 1; l <= m; l++) begin : upLvl
			for (genvar j = 0; j < n; j++) begin : node
				if (((j + 1) % (1 << l)) == 0) begin : black
					localparam int src = j - (1 << (l - 1));
					assign gT[l][j] = gT[l-1][j] | (pT[l-1][j] & gT[l-1][src]);
					assign pT[l][j] = pT[l-1][j] & pT[l-1][src];
				end else begin : white
					assign gT[l][j] = gT[l-1][j];
					assign pT[l][j] = pT[l-1][j];
				end
			end
		end
		// down sweep fills in the remaining midpoints
		for (genvar l = m + 1; l < 2 * m; l++) begin : downLvl
			for (genvar j = 0; j < n; j++) begin : node
				localparam int d = 2 * m - l;
				if ((((j + 1) % (1 << d)) == (1 << (d - 1))) && (j >= (1 << d))) begin : black
					localparam int src = j - (1 << (d - 1));
					assign gT[l][j] = gT[l-1][j] | (pT[l-1][j] & gT[l-1][src]);
					assign pT[l][j] = pT[l-1][j] & pT[l-1][src];
				end else begin : white
					assign gT[l][j] = gT[l-1][j];
					assign pT[l][j] = pT[l-1][j];
				end
			end
		end
		assign GO = gT[2*m-1];
		assign PO = pT[2*m-1];
	end else begin : serial
		wire [n-1:0] gT; // ripple chain
		wire [n-1:0] pT;

		assign gT[0] = GI[0];
		assign pT[0] = PI[0];
		for (genvar j = 1; j < n; j++) begin : node
			assign gT[j] = GI[j] | (PI[j] & gT[j-1]);
			assign pT[j] = PI[j] & pT[j-1];
		end
		assign GO = gT;
		assign PO = pT;
	end

endmodule

// ==== subVZ.sv ====
`timescale 1ns/10ps

// S = A - B - CI with signed overflow V and zero flag Z
module subVZ #(
	parameter int width = 8, // word width, at least 2
	parameter int speed = 2  // prefix network choice
) (
	input logic [width-1:0] A,
	input logic [width-1:0] B,
	input logic CI, // borrow in, subtracted
	output logic [width-1:0] S,
	output logic V, // result outside signed range
	output logic Z  // S == 0, only for CI = 0
);

	logic [width-1:0] bInv;
	logic ciInv; // borrow becomes carry into bit 0
	logic [width-1:0] gIn;
	logic [width-1:0] pIn;
	logic [width-1:0] gOut;
	logic [width-1:0] pOut;

	assign bInv = ~B;
	assign ciInv = ~CI;

	// bit 0 absorbs the carry in as a full adder majority
	assign gIn[0] = (A[0] & bInv[0]) | (A[0] & ciInv) | (bInv[0] & ciInv);
	assign gIn[width-1:1] = A[width-1:1] & bInv[width-1:1];
	assign pIn = A ^ bInv; // also the half-sum bits

	prefixAndOr #(
		.width(width),
		.speed(speed)
	) prefix_i (
		.GI(gIn),
		.PI(pIn),
		.GO(gOut),
		.PO(pOut)
	);

	assign S = pIn ^ {gOut[width-2:0], ciInv};
	assign V = gOut[width-1] ^ gOut[width-2]; // carry into vs out of msb
	// all propagate means A == B
	assign Z = pOut[width-1];

endmodule

// ==== opDecode.sv ====
`timescale 1ns/10ps

module opDecode (
	input logic clk,
	input logic arstN,
	input logic req,
	input logic [2:0] op,
	input arithPkg::word_t a,
	input arithPkg::word_t b,
	input logic borrowIn,
	input logic done, // ack is high at the result stage
	arithIf.dec outIf
);
	import arithPkg::*;

	hsState_e state;
	arithOp_e opDec;
	logic accept; // take a new request this edge

	always_comb begin
		case (op)
			OP_SBC: opDec = OP_SBC;
			OP_CMP: opDec = OP_CMP;
			OP_MIN: opDec = OP_MIN;
			OP_MAX: opDec = OP_MAX;
			default: opDec = OP_SUB; // includes unused codes
		endcase
	end

	// DONE with ack already gone counts as idle, so a quick re-raise is not missed
	assign accept = req && ((state == IDLE) || ((state == DONE) && !done));

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= IDLE;
			outIf.valid <= 1'b0;
		end else begin
			outIf.valid <= accept; // single cycle strobe
			case (state)
				IDLE: if (accept) state <= BUSY;
				BUSY: if (done) state <= DONE;
				DONE: if (!done) state <= accept ? BUSY : IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			outIf.opA <= a;
			outIf.opB <= b;
			outIf.oper <= opDec;
			outIf.carry <= (opDec == OP_SBC) && borrowIn; // borrow only for SBC
		end
	end

endmodule

// ==== subExecute.sv ====
`timescale 1ns/10ps
`include "arith_consts.svh"

module subExecute (
	input logic clk,
	input logic arstN,
	arithIf.exeIn inIf,
	arithIf.exeOut outIf
);
	import arithPkg::*;

	word_t diffC; // combinational subtractor outputs
	logic ovfC;
	logic zflagC;

	subVZ #(
		.width(`ARITH_WIDTH),
		.speed(`ARITH_SPEED)
	) subVZ_i (
		.A(inIf.opA),
		.B(inIf.opB),
		.CI(inIf.carry),
		.S(diffC),
		.V(ovfC),
		.Z(zflagC)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) outIf.valid <= 1'b0;
		else outIf.valid <= inIf.valid; // strobe moves one stage on
	end

	// payload captured with the strobe and held until the next request
	always_ff @(posedge clk) begin
		if (inIf.valid) begin
			outIf.diff <= diffC;
			outIf.ovf <= ovfC;
			outIf.zflag <= zflagC;
			outIf.oper <= inIf.oper;
			outIf.carry <= inIf.carry;
			outIf.opA <= inIf.opA; // kept for min / max
			outIf.opB <= inIf.opB;
		end
	end

endmodule

// ==== resultSelect.sv ====
`timescale 1ns/10ps

module resultSelect (
	input logic clk,
	input logic arstN,
	input logic req,
	arithIf.res inIf,
	output arithPkg::word_t result,
	output logic overflow,
	output logic zero,
	output logic less,
	output logic ack,
	output logic done // back to the receiver
);
	import arithPkg::*;

	localparam int msb = $bits(word_t) - 1;

	logic lessC; // signed a < b, or a - b - borrow < 0
	logic zeroC;
	word_t resultC;
	logic reqQ; // req as seen at the last edge

	assign lessC = inIf.diff[msb] ^ inIf.ovf;
	// prefix zero flag breaks with a borrow, fall back to a reduction
	assign zeroC = inIf.carry ? ~|inIf.diff : inIf.zflag;

	always_comb begin
		case (inIf.oper)
			OP_CMP: resultC = '0; // flags only
			OP_MIN: resultC = lessC ? inIf.opA : inIf.opB;
			OP_MAX: resultC = lessC ? inIf.opB : inIf.opA;
			default: resultC = inIf.diff; // SUB, SBC
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			result <= '0;
			overflow <= 1'b0;
			zero <= 1'b0;
			less <= 1'b0;
			ack <= 1'b0;
			reqQ <= 1'b0;
		end else begin
			reqQ <= req;
			if (inIf.valid) begin
				result <= resultC;
				overflow <= inIf.ovf;
				zero <= zeroC;
				less <= lessC;
				ack <= 1'b1;
			end else if (ack && !reqQ) begin
				ack <= 1'b0; // one edge after req was seen low
			end
		end
	end

	assign done = ack;

endmodule

// ==== arithTop.sv ====
`timescale 1ns/10ps

module arithTop (
	input logic clk,
	input logic arstN,
	input logic req,
	input logic [2:0] op,
	input arithPkg::word_t a,
	input arithPkg::word_t b,
	input logic borrowIn,
	output arithPkg::word_t result,
	output logic overflow,
	output logic zero,
	output logic less,
	output logic ack
);

	arithIf decToExe ();
	arithIf exeToRes ();

	logic done; // result stage holding ack

	opDecode opDecode_i (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.op(op),
		.a(a),
		.b(b),
		.borrowIn(borrowIn),
		.done(done),
		.outIf(decToExe.dec)
	);

	subExecute subExecute_i (
		.clk(clk),
		.arstN(arstN),
		.inIf(decToExe.exeIn),
		.outIf(exeToRes.exeOut)
	);

	resultSelect resultSelect_i (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.inIf(exeToRes.res),
		.result(result),
		.overflow(overflow),
		.zero(zero),
		.less(less),
		.ack(ack),
		.done(done)
	);

endmodule

// ==== arith_checker.sv ====
`timescale 1ns/10ps

// handshake and output checks, bound onto arithTop
module arithChecker (
	input logic clk,
	input logic arstN,
	input logic req,
	input logic ack,
	input arithPkg::word_t result,
	input logic overflow,
	input logic zero,
	input logic less
);

	int failCount = 0; // watched by the testbench

	// ack only answers a request that was up at the edge before
	ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
		$rose(ack) |-> $past(req))
	else begin
		failCount++;
		$error("ack rose although req was low");
	end

	// req seen low at one edge, ack cleared at the next
	ackRelease: assert property (@(posedge clk) disable iff (!arstN)
		$fell(req) && ack |=> ack ##1 !ack)
	else begin
		failCount++;
		$error("ack did not fall one cycle after req was sampled low");
	end

	ackHoldsOutputs: assert property (@(posedge clk) disable iff (!arstN)
		ack && $past(ack) |-> $stable(result) && $stable(overflow) && $stable(zero)
			&& $stable(less))
	else begin
		failCount++;
		$error("outputs changed while ack was high");
	end

	// decode, execute, result
	ackLatency: assert property (@(posedge clk) disable iff (!arstN)
		$rose(req) |-> ##3 $rose(ack))
	else begin
		failCount++;
		$error("ack did not rise three cycles after req");
	end

endmodule

// ==== arithTb.sv ====
`timescale 1ns/10ps
`include "arith_consts.svh"

module arithTb;
	import arithPkg::*;

	localparam time period = 4ns;
	localparam int nRandom = 300; // SUB / SBC pairs
	localparam int nEdge = 5;
	localparam int nSelect = 30; // CMP, MIN, MAX and an unused code
	localparam int nHold = 10; // req held past ack
	localparam int nTotal = nRandom + nEdge + nSelect + nHold;
	localparam word_t minNeg = {1'b1, {(`ARITH_WIDTH - 1){1'b0}}};
	localparam word_t maxPos = ~minNeg;

	logic clk;
	logic arstN;
	logic req;
	logic [2:0] op;
	word_t a;
	word_t b;
	logic borrowIn;
	word_t result;
	logic overflow;
	logic zero;
	logic less;
	logic ack;
	logic [31:0] lfsr = 32'h704689c1;

	arithTop arithTop_i (.*);

	bind arithTop arithChecker arithChecker_i (.*);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
		end
		return v;
	endfunction

	// packed as {result, overflow, zero, less}
	function automatic logic [`ARITH_WIDTH+2:0] expectedResult(input logic [2:0] opc,
			input word_t x, input word_t y, input logic bin);
		logic signed [`ARITH_WIDTH+1:0] d; // true difference, two spare bits
		logic carry;
		logic ovf;
		logic lt;
		word_t r;
		carry = (opc == OP_SBC) && bin; // borrow counts for SBC only
		d = $signed(x) - $signed(y) - $signed({1'b0, carry});
		ovf = (d < -(2 ** (`ARITH_WIDTH - 1))) || (d >= 2 ** (`ARITH_WIDTH - 1));
		lt = d < 0;
		case (opc)
			OP_CMP: r = '0;
			OP_MIN: r = lt ? x : y;
			OP_MAX: r = lt ? y : x;
			default: r = d[`ARITH_WIDTH-1:0]; // SUB, SBC, unused codes
		endcase
		return {r, ovf, d[`ARITH_WIDTH-1:0] == '0, lt};
	endfunction

	task automatic checkValue(input string name, input word_t got, input word_t want);
		assert (got === want) else begin
			$display("Fail at time %0t: %s is %h, expected %h", $time, name, got, want);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	endtask

	// one four-phase handshake, req kept up for hold extra cycles
	task automatic transfer(input logic [2:0] opc, input word_t x, input word_t y,
			input logic bin, input int hold);
		word_t held;
		@(negedge clk);
		op = opc;
		a = x;
		b = y;
		borrowIn = bin;
		req = 1'b1;
		@(posedge ack);
		@(negedge clk);
		held = result;
		repeat (hold) begin
			@(negedge clk);
			checkValue("ack", ack, 1'b1);
			checkValue("result", result, held);
		end
		req = 1'b0;
		@(negedge ack);
	endtask

	initial begin : compare
		logic [`ARITH_WIDTH+2:0] want;
		forever begin
			@(posedge ack);
			want = expectedResult(op, a, b, borrowIn); // inputs held under req
			@(negedge clk);
			checkValue("result", result, want[`ARITH_WIDTH+2:3]);
			checkValue("overflow", overflow, want[2]);
			checkValue("zero", zero, want[1]);
			checkValue("less", less, want[0]);
		end
	end

	initial begin : watchdog
		#(period * (8 + 10 * nTotal + 20 * nHold));
		$display("handshake stalled, ack never came back or never dropped");
		$display("Simulation finished: FAIL");
		$fatal(1);
	end

	// first failing bound assertion ends the run
	initial begin : assertWatch
		wait (arithTop_i.arithChecker_i.failCount != 0);
		$display("a handshake assertion in the bound checker failed");
		$display("Simulation finished: FAIL");
		$fatal(1);
	end

	initial begin : stimulus
		logic [2:0] opc;
		word_t x;
		word_t y;
		logic bin;
		arstN = 1'b0;
		req = 1'b0;
		op = OP_SUB;
		a = '0;
		b = '0;
		borrowIn = 1'b0;
		repeat (8) @(negedge clk);
		arstN = 1'b1;
		@(negedge clk);
		checkValue("ack", ack, 1'b0);
		checkValue("result", result, '0);
		checkValue("overflow", overflow, 1'b0);
		checkValue("zero", zero, 1'b0);
		checkValue("less", less, 1'b0);

		for (int i = 0; i < nRandom; i++) begin
			opc = randBits(1) ? OP_SBC : OP_SUB;
			x = randBits(`ARITH_WIDTH);
			y = randBits(`ARITH_WIDTH);
			bin = randBits(1);
			transfer(opc, x, y, bin, 0);
		end

		transfer(OP_SUB, minNeg, word_t'(1), 1'b0, 0); // wraps to max positive
		transfer(OP_SUB, maxPos, '1, 1'b0, 0); // max positive minus minus one
		x = randBits(`ARITH_WIDTH);
		transfer(OP_SUB, x, x, 1'b0, 0);
		transfer(OP_SBC, x + 1'b1, x, 1'b1, 0); // zero only through the borrow
		transfer(OP_SBC, minNeg, '0, 1'b1, 0);

		for (int i = 0; i < nSelect; i++) begin
			opc = 3'd2 + randBits(2); // CMP, MIN, MAX or unused code 5
			x = randBits(`ARITH_WIDTH);
			y = (i % 10 == 0) ? x : word_t'(randBits(`ARITH_WIDTH));
			bin = randBits(1);
			transfer(opc, x, y, bin, 0);
		end

		for (int i = 0; i < nHold; i++) begin
			opc = randBits(3);
			x = randBits(`ARITH_WIDTH);
			y = randBits(`ARITH_WIDTH);
			bin = randBits(1);
			transfer(opc, x, y, bin, randBits(5) % 21);
		end

		repeat (4) @(negedge clk); // let the last assertions finish
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
arithPkg.sv
arithIf.sv
prefixAndOr.sv
subVZ.sv
opDecode.sv
subExecute.sv
resultSelect.sv
arithTop.sv
arith_checker.sv
arithTb.sv
